// ==== Bender.yml ====
package:
  name: m6502_cpu

sources:
  - design/m6502_isa_pkg.sv
  - design/m6502_bus_pkg.sv
  - design/m6502_decode.sv
  - design/m6502_alu.sv
  - design/m6502_bus_seq.sv
  - design/m6502_regfile.sv
  - design/m6502_cpu.sv
  - target: simulation
    files:
      - sim/m6502_mem_model.sv
      - sim/m6502_cpu_tb.sv

// ==== design/m6502_alu.sv ====
// 8-bit ALU for add, logic, compare, step and shift operations
// with the N, V, Z and C flag registers
module m6502_alu
   import m6502_isa_pkg::*;
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              alu_en_i,
   input  alu_op_t           alu_op_i,
   input  logic [DATA_W-1:0] op_a_i,
   input  logic [DATA_W-1:0] op_b_i,
   input  logic              sub_i,
   output logic [DATA_W-1:0] result_o,
   output logic              flag_n_o,
   output logic              flag_v_o,
   output logic              flag_z_o,
   output logic              flag_c_o
);

   localparam int MSB = DATA_W - 1;

   logic [DATA_W-1:0] b_eff;
   logic [DATA_W:0]   sum;
   logic [DATA_W:0]   diff;
   logic              carry;
   logic              ovf;

   assign b_eff = sub_i ? ~op_b_i : op_b_i;  // SBC is ADC of the inverted operand
   assign sum   = {1'b0, op_a_i} + {1'b0, b_eff} + {{DATA_W{1'b0}}, flag_c_o};
   assign diff  = {1'b0, op_a_i} + {1'b0, ~op_b_i} + {{DATA_W{1'b0}}, 1'b1};

   always_comb
   begin
      result_o = op_a_i;
      carry    = flag_c_o;
      ovf      = flag_v_o;
      case (alu_op_i)
         ALU_ADC:
         begin
            result_o = sum[MSB:0];
            carry    = sum[DATA_W];
            ovf      = (op_a_i[MSB] == b_eff[MSB]) && (sum[MSB] != op_a_i[MSB]);
         end
         ALU_AND: result_o = op_a_i & op_b_i;
         ALU_OR:  result_o = op_a_i | op_b_i;
         ALU_EOR: result_o = op_a_i ^ op_b_i;
         ALU_CMP:
         begin
            result_o = diff[MSB:0];
            carry    = diff[DATA_W];  // Set when no borrow
         end
         ALU_INC: result_o = op_a_i + DATA_W'(1);
         ALU_DEC: result_o = op_a_i - DATA_W'(1);
         ALU_ASL:
         begin
            result_o = {op_a_i[MSB-1:0], 1'b0};
            carry    = op_a_i[MSB];
         end
         ALU_LSR:
         begin
            result_o = {1'b0, op_a_i[MSB:1]};
            carry    = op_a_i[0];
         end
         ALU_ROL:
         begin
            result_o = {op_a_i[MSB-1:0], flag_c_o};
            carry    = op_a_i[MSB];
         end
         ALU_ROR:
         begin
            result_o = {flag_c_o, op_a_i[MSB:1]};
            carry    = op_a_i[0];
         end
         ALU_CLC: carry = 1'b0;
         ALU_SEC: carry = 1'b1;
         ALU_CLV: ovf = 1'b0;
         default: result_o = op_a_i;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_n_o <= 1'b0;
         flag_v_o <= 1'b0;
         flag_z_o <= 1'b0;
         flag_c_o <= 1'b0;
      end
      else if (alu_en_i)
      begin
         flag_c_o <= carry;
         flag_v_o <= ovf;
         if (!(alu_op_i inside {ALU_CLC, ALU_SEC, ALU_CLV}))  // Flag ops leave N and Z
         begin
            flag_n_o <= result_o[MSB];
            flag_z_o <= result_o == '0;
         end
      end
   end

endmodule

// ==== design/m6502_bus_pkg.sv ====
// Memory bus widths, reset vector and bus sequencer states
package m6502_bus_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   localparam logic [ADDR_W-1:0] RESET_VECTOR = 16'hFFFC;

   typedef enum logic [3:0] {
      RESET_LO,     // Vector low byte
      RESET_HI,
      FETCH,
      DECODE,       // Decoder outputs become valid
      OPERAND_LO,
      OPERAND_HI,
      MEM_READ,
      EXECUTE,
      STORE
   } bus_state_t;

endpackage

// ==== design/m6502_bus_seq.sv ====
// Bus sequencer: reset vector load, opcode fetch, operand and data reads,
// stores, program counter, JMP and relative branches
module m6502_bus_seq
   import m6502_isa_pkg::*;
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic [DATA_W-1:0] rd_data_i,
   input  logic              ready_i,
   input  op_t               op_i,
   input  amode_t            amode_i,
   input  logic              flag_n_i,
   input  logic              flag_v_i,
   input  logic              flag_z_i,
   input  logic              flag_c_i,
   output logic [ADDR_W-1:0] addr_o,
   output logic              rd_req_o,
   output logic              wr_en_o,
   output logic [DATA_W-1:0] opcode_o,
   output logic              opcode_valid_o,
   output logic [DATA_W-1:0] operand_o,
   output logic              alu_en_o,
   output logic              wb_en_o
);

   bus_state_t        state;
   logic              started;   // Low for one cycle after reset
   logic              issued;    // Waiting for ready_i
   logic [ADDR_W-1:0] pc;
   logic [ADDR_W-1:0] ea;
   logic [2:0]        br_aaa;
   logic              rd_state;
   logic              rd_done;
   logic              is_branch;
   logic              is_store;
   logic              taken;

   assign rd_state = state inside {RESET_LO, RESET_HI, FETCH, OPERAND_LO, OPERAND_HI, MEM_READ};
   assign rd_req_o = started && rd_state && !issued;
   assign rd_done  = started && rd_state && ready_i;
   assign wr_en_o  = state == STORE;

   assign opcode_o       = rd_data_i;
   assign opcode_valid_o = (state == FETCH) && rd_done;

   assign is_branch = op_i inside {OP_BPL, OP_BMI, OP_BVC, OP_BVS, OP_BCC, OP_BCS, OP_BNE, OP_BEQ};
   assign is_store  = op_i inside {OP_STA, OP_STX, OP_STY};
   assign alu_en_o  = (state == EXECUTE) && !is_branch && (op_i != OP_NOP);
   assign wb_en_o   = alu_en_o &&
                      !(op_i inside {OP_CMP, OP_CPX, OP_CPY, OP_CLC, OP_SEC, OP_CLV});

   // aaa[2:1] picks N, V, C or Z and aaa[0] is the value that branches
   always_comb
   begin
      case (br_aaa[2:1])
         2'b00:   taken = flag_n_i == br_aaa[0];
         2'b01:   taken = flag_v_i == br_aaa[0];
         2'b10:   taken = flag_c_i == br_aaa[0];
         default: taken = flag_z_i == br_aaa[0];
      endcase
   end

   always_comb
   begin
      case (state)
         RESET_LO:        addr_o = RESET_VECTOR;
         RESET_HI:        addr_o = RESET_VECTOR + ADDR_W'(1);
         MEM_READ, STORE: addr_o = ea;
         default:         addr_o = pc;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state   <= RESET_LO;
         started <= 1'b0;
         issued  <= 1'b0;
      end
      else
      begin
         started <= 1'b1;
         if (rd_done)
            issued <= 1'b0;
         else if (rd_req_o)
            issued <= 1'b1;
         case (state)
            RESET_LO:
               if (rd_done)
               begin
                  ea[DATA_W-1:0] <= rd_data_i;
                  state          <= RESET_HI;
               end
            RESET_HI:
               if (rd_done)
               begin
                  pc    <= {rd_data_i, ea[DATA_W-1:0]};  // Vector, low byte first
                  state <= FETCH;
               end
            FETCH:
               if (rd_done)
               begin
                  br_aaa <= rd_data_i[OPC_AAA_LSB +: 3];
                  pc     <= pc + ADDR_W'(1);
                  state  <= DECODE;
               end
            DECODE:
               state <= (amode_i inside {AM_IMPLIED, AM_ACCUM}) ? EXECUTE : OPERAND_LO;
            OPERAND_LO:
               if (rd_done)
               begin
                  operand_o <= rd_data_i;
                  ea        <= {{(ADDR_W - DATA_W){1'b0}}, rd_data_i};
                  pc        <= pc + ADDR_W'(1);
                  if (amode_i == AM_ABS)
                     state <= OPERAND_HI;
                  else if (amode_i == AM_IMM)
                     state <= EXECUTE;
                  else
                     state <= is_store ? STORE : MEM_READ;
               end
            OPERAND_HI:
               if (rd_done)
               begin
                  ea[ADDR_W-1:DATA_W] <= rd_data_i;
                  if (op_i == OP_JMP)
                  begin
                     pc    <= {rd_data_i, ea[DATA_W-1:0]};
                     state <= FETCH;
                  end
                  else
                  begin
                     pc    <= pc + ADDR_W'(1);
                     state <= is_store ? STORE : MEM_READ;
                  end
               end
            MEM_READ:
               if (rd_done)
               begin
                  operand_o <= rd_data_i;
                  state     <= EXECUTE;
               end
            EXECUTE:
            begin
               if (is_branch && taken)  // PC already points past the offset
                  pc <= pc + {{(ADDR_W - DATA_W){operand_o[DATA_W-1]}}, operand_o};
               state <= FETCH;
            end
            default: state <= FETCH;
         endcase
      end
   end

   no_rd_and_wr: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req_o && wr_en_o));

   addr_held_in_wait: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req_o || issued) && !ready_i |=> $stable(addr_o));

endmodule

// ==== design/m6502_cpu.sv ====
// 6502 subset CPU top level with sequencer, decoder, ALU and register file
module m6502_cpu
   import m6502_isa_pkg::*;
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   output logic [ADDR_W-1:0] addr_o,
   output logic              rd_req_o,
   input  logic [DATA_W-1:0] rd_data_i,
   input  logic              ready_i,
   output logic [DATA_W-1:0] wr_data_o,
   output logic              wr_en_o
);

   logic [DATA_W-1:0] opcode;
   logic              opcode_valid;
   logic [DATA_W-1:0] operand;
   logic              alu_en;
   logic              wb_en;
   op_t               op;
   amode_t            amode;
   alu_op_t           alu_op;
   dest_t             dest;
   src_t              src;
   logic [DATA_W-1:0] alu_a;
   logic [DATA_W-1:0] result;
   logic              flag_n;
   logic              flag_v;
   logic              flag_z;
   logic              flag_c;

   m6502_bus_seq m6502_bus_seq_i (
      .clk            (clk),
      .reset_n        (reset_n),
      .rd_data_i      (rd_data_i),
      .ready_i        (ready_i),
      .op_i           (op),
      .amode_i        (amode),
      .flag_n_i       (flag_n),
      .flag_v_i       (flag_v),
      .flag_z_i       (flag_z),
      .flag_c_i       (flag_c),
      .addr_o         (addr_o),
      .rd_req_o       (rd_req_o),
      .wr_en_o        (wr_en_o),
      .opcode_o       (opcode),
      .opcode_valid_o (opcode_valid),
      .operand_o      (operand),
      .alu_en_o       (alu_en),
      .wb_en_o        (wb_en)
   );

   m6502_decode m6502_decode_i (
      .clk            (clk),
      .reset_n        (reset_n),
      .opcode_i       (opcode),
      .opcode_valid_i (opcode_valid),
      .op_o           (op),
      .amode_o        (amode),
      .alu_op_o       (alu_op),
      .dest_o         (dest),
      .src_o          (src)
   );

   m6502_alu m6502_alu_i (
      .clk      (clk),
      .reset_n  (reset_n),
      .alu_en_i (alu_en),
      .alu_op_i (alu_op),
      .op_a_i   (alu_a),
      .op_b_i   (operand),
      .sub_i    (op == OP_SBC),
      .result_o (result),
      .flag_n_o (flag_n),
      .flag_v_o (flag_v),
      .flag_z_o (flag_z),
      .flag_c_o (flag_c)
   );

   m6502_regfile m6502_regfile_i (
      .clk          (clk),
      .reset_n      (reset_n),
      .wb_en_i      (wb_en),
      .dest_i       (dest),
      .src_i        (src),
      .op_i         (op),
      .result_i     (result),
      .operand_i    (operand),
      .alu_a_o      (alu_a),
      .store_data_o (wr_data_o)
   );

endmodule

// ==== design/m6502_decode.sv ====
// Opcode decoder: operation, addressing mode, ALU function and register
// selects, registered on the opcode strobe
module m6502_decode
   import m6502_isa_pkg::*;
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic [DATA_W-1:0] opcode_i,
   input  logic              opcode_valid_i,
   output op_t               op_o,
   output amode_t            amode_o,
   output alu_op_t           alu_op_o,
   output dest_t             dest_o,
   output src_t              src_o
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   amode_t     mem_mode;
   op_t        op_n;
   amode_t     amode_n;
   alu_op_t    alu_op_n;
   dest_t      dest_n;
   src_t       src_n;

   assign aaa = opcode_i[OPC_AAA_LSB +: 3];
   assign bbb = opcode_i[OPC_BBB_LSB +: 3];
   assign cc  = opcode_i[OPC_CC_LSB +: 2];

   assign mem_mode = (bbb == 3'd0) ? AM_IMM : (bbb == 3'd1) ? AM_ZP : AM_ABS;  // cc 00 and 10

   always_comb
   begin
      op_n    = OP_NOP;
      amode_n = AM_IMPLIED;
      case (cc)  // Group first
         2'b01:
            if (bbb inside {3'd1, 3'd2, 3'd3})
            begin
               amode_n = (bbb == 3'd2) ? AM_IMM : (bbb == 3'd1) ? AM_ZP : AM_ABS;
               case (aaa)
                  3'd0:    op_n = OP_ORA;
                  3'd1:    op_n = OP_AND;
                  3'd2:    op_n = OP_EOR;
                  3'd3:    op_n = OP_ADC;
                  3'd4:    op_n = (bbb == 3'd2) ? OP_NOP : OP_STA;
                  3'd5:    op_n = OP_LDA;
                  3'd6:    op_n = OP_CMP;
                  default: op_n = OP_SBC;
               endcase
            end
         2'b10:
            if (bbb == 3'd2)
            begin
               amode_n = aaa[2] ? AM_IMPLIED : AM_ACCUM;
               case (aaa)
                  3'd0:    op_n = OP_ASL;
                  3'd1:    op_n = OP_ROL;
                  3'd2:    op_n = OP_LSR;
                  3'd3:    op_n = OP_ROR;
                  3'd4:    op_n = OP_TXA;
                  3'd5:    op_n = OP_TAX;
                  3'd6:    op_n = OP_DEX;
                  default: op_n = OP_NOP;
               endcase
            end
            else if (aaa == 3'd4 && bbb inside {3'd1, 3'd3})
            begin
               op_n    = OP_STX;
               amode_n = mem_mode;
            end
            else if (aaa == 3'd5 && bbb inside {3'd0, 3'd1, 3'd3})
            begin
               op_n    = OP_LDX;
               amode_n = mem_mode;
            end
         2'b00:
            if (bbb == 3'd4)
            begin
               amode_n = AM_IMM;
               case (aaa)
                  3'd0:    op_n = OP_BPL;
                  3'd1:    op_n = OP_BMI;
                  3'd2:    op_n = OP_BVC;
                  3'd3:    op_n = OP_BVS;
                  3'd4:    op_n = OP_BCC;
                  3'd5:    op_n = OP_BCS;
                  3'd6:    op_n = OP_BNE;
                  default: op_n = OP_BEQ;
               endcase
            end
            else if (bbb == 3'd6)
            begin
               case (aaa)
                  3'd0:    op_n = OP_CLC;
                  3'd1:    op_n = OP_SEC;
                  3'd4:    op_n = OP_TYA;
                  3'd5:    op_n = OP_CLV;
                  default: op_n = OP_NOP;
               endcase
            end
            else if (bbb == 3'd2)
            begin
               case (aaa)
                  3'd4:    op_n = OP_DEY;
                  3'd5:    op_n = OP_TAY;
                  3'd6:    op_n = OP_INY;
                  3'd7:    op_n = OP_INX;
                  default: op_n = OP_NOP;
               endcase
            end
            else if (bbb inside {3'd0, 3'd1, 3'd3})
            begin
               amode_n = mem_mode;
               case (aaa)
                  3'd2:    op_n = (bbb == 3'd3) ? OP_JMP : OP_NOP;
                  3'd4:    op_n = (bbb == 3'd0) ? OP_NOP : OP_STY;
                  3'd5:    op_n = OP_LDY;
                  3'd6:    op_n = OP_CPY;
                  3'd7:    op_n = OP_CPX;
                  default: op_n = OP_NOP;
               endcase
            end
         default: op_n = OP_NOP;
      endcase
      if (op_n == OP_NOP)
         amode_n = AM_IMPLIED;
   end

   always_comb
   begin
      case (op_n)
         OP_ADC, OP_SBC:         alu_op_n = ALU_ADC;
         OP_AND:                 alu_op_n = ALU_AND;
         OP_ORA:                 alu_op_n = ALU_OR;
         OP_EOR:                 alu_op_n = ALU_EOR;
         OP_CMP, OP_CPX, OP_CPY: alu_op_n = ALU_CMP;
         OP_INX, OP_INY:         alu_op_n = ALU_INC;
         OP_DEX, OP_DEY:         alu_op_n = ALU_DEC;
         OP_ASL:                 alu_op_n = ALU_ASL;
         OP_LSR:                 alu_op_n = ALU_LSR;
         OP_ROL:                 alu_op_n = ALU_ROL;
         OP_ROR:                 alu_op_n = ALU_ROR;
         OP_CLC:                 alu_op_n = ALU_CLC;
         OP_SEC:                 alu_op_n = ALU_SEC;
         OP_CLV:                 alu_op_n = ALU_CLV;
         default:                alu_op_n = ALU_PASS;
      endcase
      case (op_n)
         OP_LDA, OP_TXA, OP_TYA, OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
         OP_ASL, OP_LSR, OP_ROL, OP_ROR: dest_n = DEST_A;
         OP_LDX, OP_TAX, OP_INX, OP_DEX: dest_n = DEST_X;
         OP_LDY, OP_TAY, OP_INY, OP_DEY: dest_n = DEST_Y;
         default:                        dest_n = DEST_NONE;
      endcase
      case (op_n)
         OP_STX, OP_CPX, OP_INX, OP_DEX, OP_TXA: src_n = SRC_X;
         OP_STY, OP_CPY, OP_INY, OP_DEY, OP_TYA: src_n = SRC_Y;
         default:                                src_n = SRC_A;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         op_o     <= OP_NOP;
         amode_o  <= AM_IMPLIED;
         alu_op_o <= ALU_PASS;
         dest_o   <= DEST_NONE;
         src_o    <= SRC_A;
      end
      else if (opcode_valid_i)
      begin
         op_o     <= op_n;
         amode_o  <= amode_n;
         alu_op_o <= alu_op_n;
         dest_o   <= dest_n;
         src_o    <= src_n;
      end
   end

   accum_is_shift: assert property (@(posedge clk) disable iff (!reset_n)
      amode_o == AM_ACCUM |-> alu_op_o inside {ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR});

endmodule

// ==== design/m6502_isa_pkg.sv ====
// 6502 subset instruction set: operations, addressing modes, ALU functions
// and register selects, plus the opcode field layout
package m6502_isa_pkg;

   // Opcode layout is aaabbbcc
   localparam int OPC_AAA_LSB = 5;
   localparam int OPC_BBB_LSB = 2;
   localparam int OPC_CC_LSB  = 0;

   typedef enum logic [5:0] {
      OP_ADC, OP_AND, OP_ASL,
      OP_BCC, OP_BCS, OP_BEQ, OP_BMI,
      OP_BNE, OP_BPL, OP_BVC, OP_BVS,
      OP_CLC, OP_CLV, OP_CMP, OP_CPX, OP_CPY,
      OP_DEX, OP_DEY, OP_EOR, OP_INX, OP_INY,
      OP_JMP, OP_LDA, OP_LDX, OP_LDY, OP_LSR,
      OP_ORA, OP_ROL, OP_ROR, OP_SBC, OP_SEC,
      OP_STA, OP_STX, OP_STY,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA,
      OP_NOP
   } op_t;

   typedef enum logic [2:0] {
      AM_IMPLIED,
      AM_ACCUM,
      AM_IMM,      // Also the relative offset of branches
      AM_ZP,
      AM_ABS
   } amode_t;

   typedef enum logic [3:0] {
      ALU_PASS, ALU_ADC, ALU_AND, ALU_OR, ALU_EOR,
      ALU_CMP, ALU_INC, ALU_DEC,
      ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR,
      ALU_CLC, ALU_SEC, ALU_CLV
   } alu_op_t;

   typedef enum logic [1:0] {
      DEST_NONE,
      DEST_A,
      DEST_X,
      DEST_Y
   } dest_t;

   typedef enum logic [1:0] {
      SRC_A,
      SRC_X,
      SRC_Y
   } src_t;

endpackage

// ==== design/m6502_regfile.sv ====
// A, X and Y registers with writeback, ALU operand and store data selection
module m6502_regfile
   import m6502_isa_pkg::*;
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              wb_en_i,
   input  dest_t             dest_i,
   input  src_t              src_i,
   input  op_t               op_i,
   input  logic [DATA_W-1:0] result_i,
   input  logic [DATA_W-1:0] operand_i,
   output logic [DATA_W-1:0] alu_a_o,
   output logic [DATA_W-1:0] store_data_o
);

   logic [DATA_W-1:0] reg_a;
   logic [DATA_W-1:0] reg_x;
   logic [DATA_W-1:0] reg_y;
   logic [DATA_W-1:0] src_val;

   always_comb
   begin
      case (src_i)
         SRC_X:   src_val = reg_x;
         SRC_Y:   src_val = reg_y;
         default: src_val = reg_a;
      endcase
   end

   // Loads go through the ALU so N and Z follow the loaded byte
   assign alu_a_o      = (op_i inside {OP_LDA, OP_LDX, OP_LDY}) ? operand_i : src_val;
   assign store_data_o = src_val;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
      end
      else if (wb_en_i)
      begin
         case (dest_i)
            DEST_A:  reg_a <= result_i;
            DEST_X:  reg_x <= result_i;
            DEST_Y:  reg_y <= result_i;
            default: reg_a <= reg_a;
         endcase
      end
   end

endmodule

// ==== sim/m6502_cpu_tb.sv ====
// CPU testbench with clock, reset, program image, checking assertions and error counts
module m6502_cpu_tb
   import m6502_bus_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          TIMEOUT   = 20000;
   localparam logic [15:0] PROG_BASE = 16'h0800;
   localparam logic [15:0] SKIP_ADDR = 16'h0310;

   logic              clk;
   logic              reset_n;
   logic [ADDR_W-1:0] addr;
   logic              rd_req;
   logic [DATA_W-1:0] rd_data;
   logic              ready;
   logic [DATA_W-1:0] wr_data;
   logic              wr_en;

   int                mismatch_errs = 0;
   int                protocol_errs = 0;
   int                timeout_errs  = 0;
   logic [15:0]       prog_pc;
   logic [7:0]        zp_next;
   logic [7:0]        exp_val [int];
   string             exp_name [int];
   logic [15:0]       rd_addrs [$];

   m6502_cpu m6502_cpu_i (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (addr),
      .rd_req_o  (rd_req),
      .rd_data_i (rd_data),
      .ready_i   (ready),
      .wr_data_o (wr_data),
      .wr_en_o   (wr_en)
   );

   m6502_mem_model mem_model_i (
      .clk       (clk),
      .addr_i    (addr),
      .rd_req_i  (rd_req),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .rd_data_o (rd_data),
      .ready_o   (ready)
   );

   always #4 clk = ~clk;

   always @(negedge clk)
      if (rd_req && rd_addrs.size() < 3)
         rd_addrs.push_back(addr);

   quiet_in_reset: assert property (@(posedge clk) !reset_n |=> !rd_req && !wr_en)
      else
      begin
         protocol_errs++;
         $display("bus request seen during reset");
      end
   quiet_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !rd_req && !wr_en)
      else
      begin
         protocol_errs++;
         $display("bus request in the first cycle after reset");
      end
   skip_not_written: assert property (@(posedge clk) disable iff (!reset_n)
      wr_en |-> addr != SKIP_ADDR)
      else
      begin
         protocol_errs++;
         $display("write at the address that JMP skips");
      end

   task automatic put(input logic [7:0] b);
      mem_model_i.mem[prog_pc] = b;
      prog_pc++;
   endtask

   task automatic put_imm(input logic [7:0] opc, input logic [7:0] v);
      put(opc);
      put(v);
   endtask

   task automatic put_abs(input logic [7:0] opc, input logic [15:0] a);
      put(opc);
      put(a[7:0]);
      put(a[15:8]);
   endtask

   task automatic expect_write(input int a, input logic [7:0] v, input string name);
      exp_val[a]  = v;
      exp_name[a] = name;
   endtask

   task automatic store_zp(input logic [7:0] opc, input logic [7:0] v, input string name);
      put(opc);
      put(zp_next);
      expect_write(zp_next, v, name);
      zp_next++;
   endtask

   // Marker in X tells which path ran
   task automatic branch_test(input logic [7:0] opc, input int setup, input bit backward);
      logic        n;
      logic        v;
      logic        z;
      logic        c;
      bit          tk;
      logic [15:0] jmp1;
      logic [15:0] jmp2;
      logic [15:0] l1;
      logic [15:0] l3;
      n = 1'b0;
      v = 1'b0;
      z = 1'b0;
      c = 1'b0;
      if (backward)
      begin
         jmp1 = prog_pc;
         put_abs(8'h4C, 16'h0000);
         l1 = prog_pc;
         put_imm(8'hA2, 8'hA5);
         jmp2 = prog_pc;
         put_abs(8'h4C, 16'h0000);
         mem_model_i.mem[jmp1 + 1] = prog_pc[7:0];
         mem_model_i.mem[jmp1 + 2] = prog_pc[15:8];
      end
      else
         put_imm(8'hA2, 8'hA5);
      case (setup)
         0:
         begin
            put_imm(8'hA9, 8'h10);
            put_imm(8'hC9, 8'h20);
            n = 1'b1;
         end
         1:
         begin
            put_imm(8'hA9, 8'h20);
            put_imm(8'hC9, 8'h20);
            z = 1'b1;
            c = 1'b1;
         end
         2:
         begin
            put(8'h18);
            put_imm(8'hA9, 8'h7F);
            put_imm(8'h69, 8'h01);
            n = 1'b1;
            v = 1'b1;
         end
         default: put(8'hB8);
      endcase
      case (opc)
         8'h10:   tk = !n;
         8'h30:   tk = n;
         8'h50:   tk = !v;
         8'h70:   tk = v;
         8'h90:   tk = !c;
         8'hB0:   tk = c;
         8'hD0:   tk = !z;
         default: tk = z;
      endcase
      put(opc);
      put(backward ? 8'(l1 - (prog_pc + 16'd1)) : 8'h02);  // Relative to next instruction
      put_imm(8'hA2, 8'h5A);
      if (backward)
      begin
         l3 = prog_pc;
         mem_model_i.mem[jmp2 + 1] = l3[7:0];
         mem_model_i.mem[jmp2 + 2] = l3[15:8];
      end
      store_zp(8'h86, tk ? 8'hA5 : 8'h5A,
         $sformatf("branch_%h_setup%0d%s", opc, setup, backward ? "_back" : ""));
   endtask

   initial
   begin
      logic [7:0]  a;
      logic [7:0]  b;
      logic [8:0]  s;
      logic [7:0]  br_opc [8];
      logic [15:0] jpos;
      logic [15:0] end_addr;
      int          cycles;
      bit          done;
      void'($urandom(46));
      clk     = 1'b0;
      reset_n = 1'b0;
      mem_model_i.draw_latency();
      mem_model_i.fill();
      mem_model_i.mem[16'hFFFC] = PROG_BASE[7:0];
      mem_model_i.mem[16'hFFFD] = PROG_BASE[15:8];
      prog_pc = PROG_BASE;
      zp_next = 8'h10;

      a = $urandom;
      put_imm(8'hA9, a);
      store_zp(8'h85, a, "lda_imm_sta_zp");
      a = $urandom;
      mem_model_i.mem[16'h0400] = a;
      put_abs(8'hAE, 16'h0400);
      put_abs(8'h8E, 16'h0300);
      expect_write(16'h0300, a, "ldx_abs");
      a = $urandom;
      put_imm(8'hA0, a);
      store_zp(8'h84, a, "ldy_imm_sty_zp");
      a = $urandom;
      mem_model_i.mem[16'h0401] = a;
      put_abs(8'hAD, 16'h0401);
      put_abs(8'h8D, 16'h0301);
      expect_write(16'h0301, a, "lda_abs");
      a = $urandom;
      put_imm(8'hA2, a);
      store_zp(8'h86, a, "ldx_imm_stx_zp");
      a = $urandom;
      mem_model_i.mem[16'h0402] = a;
      put_abs(8'hAC, 16'h0402);
      put_abs(8'h8C, 16'h0302);
      expect_write(16'h0302, a, "ldy_abs");

      a = $urandom;
      b = $urandom;
      s = a + b;
      put(8'h18);
      put_imm(8'hA9, a);
      put_imm(8'h69, b);
      store_zp(8'h85, s[7:0], "adc");
      put_imm(8'hA9, 8'h00);
      put_imm(8'h69, 8'h00);
      store_zp(8'h85, {7'd0, s[8]}, "adc_carry");
      a = $urandom;
      b = $urandom;
      put(8'h38);
      put_imm(8'hA9, a);
      put_imm(8'hE9, b);
      store_zp(8'h85, a - b, "sbc");
      put_imm(8'hA9, 8'h00);
      put_imm(8'h69, 8'h00);
      store_zp(8'h85, {7'd0, a >= b}, "sbc_carry");
      a = $urandom;
      b = $urandom;
      put_imm(8'hA9, a);
      put_imm(8'h29, b);
      store_zp(8'h85, a & b, "and");
      put_imm(8'hA9, a);
      put_imm(8'h09, b);
      store_zp(8'h85, a | b, "ora");
      put_imm(8'hA9, a);
      put_imm(8'h49, b);
      store_zp(8'h85, a ^ b, "eor");

      a = $urandom;
      put_imm(8'hA9, a);
      put(8'h0A);
      store_zp(8'h85, {a[6:0], 1'b0}, "asl_a");
      put_imm(8'hA9, a);
      put(8'h4A);
      store_zp(8'h85, {1'b0, a[7:1]}, "lsr_a");
      put(8'h38);
      put_imm(8'hA9, a);
      put(8'h2A);
      store_zp(8'h85, {a[6:0], 1'b1}, "rol_a");
      put(8'h38);
      put_imm(8'hA9, a);
      put(8'h6A);
      store_zp(8'h85, {1'b1, a[7:1]}, "ror_a");
      a = $urandom;
      put_imm(8'hA2, a);
      put(8'hE8);
      store_zp(8'h86, a + 8'd1, "inx");
      put(8'hCA);
      store_zp(8'h86, a, "dex");
      a = $urandom;
      put_imm(8'hA0, a);
      put(8'hC8);
      store_zp(8'h84, a + 8'd1, "iny");
      put(8'h88);
      store_zp(8'h84, a, "dey");
      a = $urandom;
      put_imm(8'hA9, a);
      put(8'hAA);
      store_zp(8'h86, a, "tax");
      put(8'hA8);
      store_zp(8'h84, a, "tay");
      a = $urandom;
      put_imm(8'hA2, a);
      put(8'h8A);
      store_zp(8'h85, a, "txa");
      a = $urandom;
      put_imm(8'hA0, a);
      put(8'h98);
      store_zp(8'h85, a, "tya");

      br_opc = '{8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};
      for (int k = 0; k < 8; k++)
         for (int st = 0; st < 2; st++)
            branch_test(br_opc[k], (k inside {2, 3}) ? 2 + st : st, ((k + st) % 2) == 1);

      jpos = prog_pc;
      put_abs(8'h4C, jpos + 16'd8);
      put_imm(8'hA9, 8'h55);
      put_abs(8'h8D, SKIP_ADDR);
      put_imm(8'hA9, 8'h66);
      store_zp(8'h85, 8'h66, "jmp_target");
      end_addr = prog_pc;
      put_abs(8'h4C, end_addr);  // Park here

      repeat (3) @(negedge clk);
      reset_n = 1'b1;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < TIMEOUT)
      begin
         @(negedge clk);
         done = rd_req && addr == end_addr;
         cycles++;
      end
      if (!done)
      begin
         timeout_errs++;
         $display("timeout: the program never reached its final loop");
      end

      assert (rd_addrs.size() == 3 && rd_addrs[0] == 16'hFFFC && rd_addrs[1] == 16'hFFFD &&
              rd_addrs[2] == PROG_BASE)
      else
      begin
         mismatch_errs++;
         $display("mismatch reset_vector: expected fffc fffd %h, actual %p", PROG_BASE, rd_addrs);
      end
      foreach (exp_val[i])
      begin
         if (!mem_model_i.wr_cnt.exists(i))
         begin
            mismatch_errs++;
            $display("test %s never wrote its result to %h", exp_name[i], i);
         end
         else
         begin
            assert (mem_model_i.wr_last[i] == exp_val[i])
            else
            begin
               mismatch_errs++;
               $display("mismatch %s: expected %h, actual %h", exp_name[i], exp_val[i],
                  mem_model_i.wr_last[i]);
            end
            assert (mem_model_i.wr_cnt[i] == 1)
            else
            begin
               protocol_errs++;
               $display("test %s wrote %h more than once", exp_name[i], i);
            end
         end
      end
      foreach (mem_model_i.wr_cnt[i])
         if (!exp_val.exists(i))
         begin
            protocol_errs++;
            $display("unexpected write at address %h", i);
         end

      $display("errors: mismatch %0d, protocol %0d, timeout %0d",
         mismatch_errs, protocol_errs, timeout_errs);
      if (mismatch_errs + protocol_errs + timeout_errs == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== sim/m6502_mem_model.sv ====
// Byte memory for the CPU testbench with random read latency and a write log
module m6502_mem_model
   import m6502_bus_pkg::*;
(
   input  logic              clk,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              rd_req_i,
   input  logic              wr_en_i,
   input  logic [DATA_W-1:0] wr_data_i,
   output logic [DATA_W-1:0] rd_data_o,
   output logic              ready_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];
   logic [DATA_W-1:0] wr_last [int];  // Last byte written per address
   int                wr_cnt [int];
   logic [1:0]        latency [1024];  // Read delays of 0 to 3 cycles
   logic [9:0]        rd_idx;
   int                wait_cnt;
   bit                pending;

   initial
   begin
      rd_data_o = '0;
      ready_o   = 1'b0;
      pending   = 1'b0;
      wait_cnt  = 0;
      rd_idx    = '0;
   end

   // Background pattern from both address bytes
   task automatic fill();
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < (1 << ADDR_W); i++)
      begin
         a      = ADDR_W'(i);
         mem[i] = a[15:8] ^ a[7:0] ^ 8'h5A;
      end
   endtask

   task automatic draw_latency();
      foreach (latency[i])
         latency[i] = 2'($urandom % 4);
   endtask

   always @(negedge clk)
   begin
      ready_o = 1'b0;
      if (pending)
      begin
         wait_cnt--;
         if (wait_cnt == 0)
         begin
            pending   = 1'b0;
            ready_o   = 1'b1;
            rd_data_o = mem[addr_i];
         end
      end
      else if (rd_req_i)
      begin
         wait_cnt = latency[rd_idx];
         rd_idx++;
         if (wait_cnt == 0)
         begin
            ready_o   = 1'b1;  // Same cycle as the request
            rd_data_o = mem[addr_i];
         end
         else
            pending = 1'b1;
      end
      if (wr_en_i)
      begin
         mem[addr_i]     = wr_data_i;
         wr_last[addr_i] = wr_data_i;
         wr_cnt[addr_i]  = wr_cnt.exists(addr_i) ? wr_cnt[addr_i] + 1 : 1;
      end
   end

endmodule

// ==== tb.f ====
design/m6502_isa_pkg.sv
design/m6502_bus_pkg.sv
design/m6502_decode.sv
design/m6502_alu.sv
design/m6502_bus_seq.sv
design/m6502_regfile.sv
design/m6502_cpu.sv
sim/m6502_mem_model.sv
sim/m6502_cpu_tb.sv
